/* logic/int_iq_pkg.sv */
package int_iq_pkg;

    localparam int BANK_NUM = 2;  // one bank per alu port.
    localparam int BANK_SIZE = 4;
    localparam int DISP_WIDTH = BANK_NUM;
    localparam int WB_SIZE = 2;

    localparam int PREG_WIDTH = 6;
    localparam int ROB_WIDTH = 5;  // the wrap bit is kept outside this width.
    localparam int BRANCHOP_WIDTH = 3;
    localparam int IMM_WIDTH = 20;
    localparam int ALUOP_WIDTH = 4;

    localparam int BANK_IDX_WIDTH = $clog2(BANK_NUM);
    localparam int ENTRY_IDX_WIDTH = $clog2(BANK_SIZE);
    localparam int COUNT_WIDTH = $clog2(BANK_SIZE + 1);  // must also hold the full count.

    localparam logic [BRANCHOP_WIDTH-1:0] BRANCH_JAL = 3'b100;
    localparam logic [BRANCHOP_WIDTH-1:0] BRANCH_JALR = 3'b101;

    typedef struct packed {
        logic dir;
        logic [ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic [PREG_WIDTH-1:0] rs1;
        logic [PREG_WIDTH-1:0] rs2;
        logic rs1v;
        logic rs2v;
        rob_idx_t robIdx;
    } iq_status_t;

    typedef struct packed {
        logic [PREG_WIDTH-1:0] rd;
        logic [BRANCHOP_WIDTH-1:0] branchop;
        logic [IMM_WIDTH-1:0] imm;
        rob_idx_t robIdx;
        logic [ALUOP_WIDTH-1:0] aluop;
    } iq_payload_t;

    typedef struct packed {
        logic en;
        logic we;
        logic [PREG_WIDTH-1:0] rd;
    } wakeup_t;

    typedef struct packed {
        logic valid;
        rob_idx_t redirectIdx;
    } redirect_t;

    typedef enum logic [1:0] {CONDITION, DIRECT, INDIRECT, CALL} br_type_e;
    typedef enum logic [1:0] {NONE, POP, PUSH, POP_PUSH} ras_type_e;

    typedef struct packed {
        iq_payload_t payload;
        logic [PREG_WIDTH-1:0] rs1;
        logic [PREG_WIDTH-1:0] rs2;
    } bank_issue_t;

    typedef struct packed {
        iq_payload_t payload;
        logic [PREG_WIDTH-1:0] rs1;
        logic [PREG_WIDTH-1:0] rs2;
        br_type_e br_type;
        ras_type_e ras_type;
    } issue_t;

    // true when a was allocated in the rob before b.
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        return (a.dir ^ b.dir) ^ (a.idx < b.idx);  // a wrap flip reverses the order.
    endfunction

endpackage

/* logic/oldest_ready_picker.sv */
`timescale 1ns/1ps

module oldest_ready_picker (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic [int_iq_pkg::BANK_SIZE-1:0] alloc_i,
    input  logic [int_iq_pkg::BANK_SIZE-1:0] ready_i,
    output logic [int_iq_pkg::BANK_SIZE-1:0] pick_o
);

    // age_q[i][j] is set when entry i was allocated before entry j.
    logic [int_iq_pkg::BANK_SIZE-1:0] age_q [int_iq_pkg::BANK_SIZE];
    logic [int_iq_pkg::BANK_SIZE-1:0] blocked;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
                for (int j = 0; j < int_iq_pkg::BANK_SIZE; j++) begin
                    if (alloc_i[j] && i != j) begin
                        age_q[i][j] <= 1'b1;  // every other entry predates the new one.
                    end else if (alloc_i[i]) begin
                        age_q[i][j] <= 1'b0;  // the new entry predates nobody.
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < int_iq_pkg::BANK_SIZE; j++) begin
                if (j != i && ready_i[j] && age_q[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    assign pick_o = ready_i & ~blocked;  // only the oldest ready entry is left unblocked.

endmodule

/* logic/issue_bank.sv */
`timescale 1ns/1ps

module issue_bank (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               wr_en_i,
    input  int_iq_pkg::iq_status_t             status_i,
    input  int_iq_pkg::iq_payload_t            payload_i,
    input  int_iq_pkg::wakeup_t                wakeup_i [int_iq_pkg::WB_SIZE],
    input  int_iq_pkg::redirect_t              redirect_i,
    input  logic                               grant_i,
    output logic                               full_o,
    output logic [int_iq_pkg::COUNT_WIDTH-1:0] count_o,
    output logic                               pick_en_o,
    output int_iq_pkg::bank_issue_t            pick_o
);

    logic [int_iq_pkg::BANK_SIZE-1:0] valid_q;
    logic [int_iq_pkg::BANK_SIZE-1:0] valid_d;
    logic [int_iq_pkg::BANK_SIZE-1:0] free_oh;
    logic [int_iq_pkg::BANK_SIZE-1:0] alloc;
    logic [int_iq_pkg::BANK_SIZE-1:0] ready;
    logic [int_iq_pkg::BANK_SIZE-1:0] pick;
    logic [int_iq_pkg::BANK_SIZE-1:0] granted;
    logic [int_iq_pkg::BANK_SIZE-1:0] keep;
    logic [int_iq_pkg::BANK_SIZE-1:0] rs1_hit;
    logic [int_iq_pkg::BANK_SIZE-1:0] rs2_hit;
    logic new_rs1_hit;
    logic new_rs2_hit;
    logic new_keep;
    int_iq_pkg::iq_status_t new_status;
    int_iq_pkg::iq_status_t status_q [int_iq_pkg::BANK_SIZE];
    int_iq_pkg::iq_payload_t payload_q [int_iq_pkg::BANK_SIZE];
    logic [int_iq_pkg::ENTRY_IDX_WIDTH-1:0] pick_idx;

    assign free_oh = ~valid_q & (valid_q + 1'b1);  // lowest clear bit of the valid vector.
    assign alloc = {int_iq_pkg::BANK_SIZE{wr_en_i}} & free_oh;
    assign full_o = &valid_q;

    always_comb begin
        count_o = '0;
        for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
            count_o = count_o + {{(int_iq_pkg::COUNT_WIDTH-1){1'b0}}, valid_q[i]};
        end
    end

    // an incoming op also listens to the broadcast, so a wakeup in its write cycle is kept.
    always_comb begin
        new_rs1_hit = 1'b0;
        new_rs2_hit = 1'b0;
        rs1_hit = '0;
        rs2_hit = '0;
        for (int p = 0; p < int_iq_pkg::WB_SIZE; p++) begin
            if (wakeup_i[p].en && wakeup_i[p].we) begin
                new_rs1_hit = new_rs1_hit | (wakeup_i[p].rd == status_i.rs1);
                new_rs2_hit = new_rs2_hit | (wakeup_i[p].rd == status_i.rs2);
                for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
                    rs1_hit[i] = rs1_hit[i] | (wakeup_i[p].rd == status_q[i].rs1);
                    rs2_hit[i] = rs2_hit[i] | (wakeup_i[p].rd == status_q[i].rs2);
                end
            end
        end
    end

    always_comb begin
        new_status = status_i;
        new_status.rs1v = status_i.rs1v | new_rs1_hit;
        new_status.rs2v = status_i.rs2v | new_rs2_hit;
    end

    assign new_keep = int_iq_pkg::rob_older(status_i.robIdx, redirect_i.redirectIdx);

    for (genvar i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin : g_entry
        assign ready[i] = valid_q[i] & status_q[i].rs1v & status_q[i].rs2v;
        assign keep[i] = int_iq_pkg::rob_older(status_q[i].robIdx, redirect_i.redirectIdx);
    end

    oldest_ready_picker picker_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .alloc_i (alloc),
        .ready_i (ready),
        .pick_o  (pick)
    );

    assign pick_en_o = (|pick) & ~redirect_i.valid;  // the flush cycle issues nothing.
    assign granted = pick & {int_iq_pkg::BANK_SIZE{pick_en_o & grant_i}};

    always_comb begin
        pick_idx = '0;
        for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
            if (pick[i]) begin
                pick_idx = i[int_iq_pkg::ENTRY_IDX_WIDTH-1:0];
            end
        end
    end

    assign pick_o.payload = payload_q[pick_idx];
    assign pick_o.rs1 = status_q[pick_idx].rs1;
    assign pick_o.rs2 = status_q[pick_idx].rs2;

    always_comb begin
        for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
            if (alloc[i]) begin
                valid_d[i] = ~redirect_i.valid | new_keep;
            end else begin
                valid_d[i] = valid_q[i] & ~granted[i] & (~redirect_i.valid | keep[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < int_iq_pkg::BANK_SIZE; i++) begin
            if (alloc[i]) begin
                status_q[i] <= new_status;
                payload_q[i] <= payload_i;
            end else begin
                status_q[i].rs1v <= status_q[i].rs1v | rs1_hit[i];
                status_q[i].rs2v <= status_q[i].rs2v | rs2_hit[i];
            end
        end
    end

    // the top must hold a slot back while any bank reports full.
    assert property (@(posedge clk) disable iff (rst_i) wr_en_i |-> !full_o)
        else $error("issue_bank: write into a full bank");

    assert property (@(posedge clk) disable iff (rst_i) $onehot0(pick))
        else $error("issue_bank: more than one entry picked");

endmodule

/* logic/bank_balance_sort.sv */
`timescale 1ns/1ps

module bank_balance_sort (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic [int_iq_pkg::COUNT_WIDTH-1:0]    count_i [int_iq_pkg::BANK_NUM],
    output logic [int_iq_pkg::BANK_IDX_WIDTH-1:0] order_o [int_iq_pkg::DISP_WIDTH]
);

    logic [int_iq_pkg::BANK_IDX_WIDTH-1:0] rank [int_iq_pkg::BANK_NUM];
    logic [int_iq_pkg::BANK_IDX_WIDTH-1:0] order_d [int_iq_pkg::DISP_WIDTH];
    logic [int_iq_pkg::BANK_NUM-1:0] seen;

    // the rank of a bank counts the banks ahead of it and equal counts keep index order.
    always_comb begin
        for (int b = 0; b < int_iq_pkg::BANK_NUM; b++) begin
            rank[b] = '0;
            for (int c = 0; c < int_iq_pkg::BANK_NUM; c++) begin
                if (count_i[c] < count_i[b] || (count_i[c] == count_i[b] && c < b)) begin
                    rank[b] = rank[b] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            order_d[k] = '0;
        end
        for (int b = 0; b < int_iq_pkg::BANK_NUM; b++) begin
            order_d[rank[b]] = b[int_iq_pkg::BANK_IDX_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            if (rst_i) begin
                order_o[k] <= k[int_iq_pkg::BANK_IDX_WIDTH-1:0];
            end else begin
                order_o[k] <= order_d[k];
            end
        end
    end

    always_comb begin
        seen = '0;
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            seen[order_o[k]] = 1'b1;
        end
    end

    // every bank must be named once, or two slots would collide in one bank.
    assert property (@(posedge clk) disable iff (rst_i) &seen)
        else $error("bank_balance_sort: order is not a permutation");

endmodule

/* logic/branch_classify.sv */
`timescale 1ns/1ps

module branch_classify (
    input  logic [int_iq_pkg::BRANCHOP_WIDTH-1:0] branchop_i,
    input  logic [int_iq_pkg::PREG_WIDTH-1:0]     rd_i,
    input  logic [int_iq_pkg::PREG_WIDTH-1:0]     rs1_i,
    output int_iq_pkg::br_type_e                  br_type_o,
    output int_iq_pkg::ras_type_e                 ras_type_o
);

    logic push;
    logic pop;

    // x1 and x5 are the link registers of the calling convention.
    assign push = (rd_i == 6'd1) || (rd_i == 6'd5);
    assign pop = (rs1_i == 6'd1) || (rs1_i == 6'd5);

    always_comb begin
        case ({push, pop})
            2'b01:   ras_type_o = int_iq_pkg::POP;
            2'b10:   ras_type_o = int_iq_pkg::PUSH;
            2'b11:   ras_type_o = int_iq_pkg::POP_PUSH;
            default: ras_type_o = int_iq_pkg::NONE;
        endcase
    end

    always_comb begin
        if (branchop_i == int_iq_pkg::BRANCH_JAL) begin
            br_type_o = int_iq_pkg::DIRECT;
        end else if (branchop_i == int_iq_pkg::BRANCH_JALR) begin
            br_type_o = (push | pop) ? int_iq_pkg::CALL : int_iq_pkg::INDIRECT;
        end else begin
            br_type_o = int_iq_pkg::CONDITION;  // conditional branches and plain alu ops.
        end
    end

endmodule

/* logic/int_issue_queue.sv */
`timescale 1ns/1ps

module int_issue_queue (
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic [int_iq_pkg::DISP_WIDTH-1:0]               disp_en_i,
    input  int_iq_pkg::iq_status_t                          disp_status_i [int_iq_pkg::DISP_WIDTH],
    input  int_iq_pkg::iq_payload_t                         disp_payload_i [int_iq_pkg::DISP_WIDTH],
    output logic                                            full_o,
    input  int_iq_pkg::wakeup_t                             wakeup_i [int_iq_pkg::WB_SIZE],
    input  int_iq_pkg::redirect_t                           redirect_i,
    input  logic [int_iq_pkg::BANK_NUM-1:0]                 exu_ready_i,
    output logic [int_iq_pkg::BANK_NUM-1:0]                 issue_en_o,
    output int_iq_pkg::issue_t                              issue_o [int_iq_pkg::BANK_NUM]
);

    logic [int_iq_pkg::BANK_NUM-1:0] bank_wr;
    logic [int_iq_pkg::BANK_NUM-1:0] bank_full;
    logic [int_iq_pkg::BANK_NUM-1:0] pick_en;
    logic [int_iq_pkg::BANK_NUM-1:0] issue_vld_q;
    logic [int_iq_pkg::BANK_NUM-1:0] issue_keep;
    int_iq_pkg::iq_status_t bank_status [int_iq_pkg::BANK_NUM];
    int_iq_pkg::iq_payload_t bank_payload [int_iq_pkg::BANK_NUM];
    logic [int_iq_pkg::COUNT_WIDTH-1:0] bank_count [int_iq_pkg::BANK_NUM];
    int_iq_pkg::bank_issue_t bank_pick [int_iq_pkg::BANK_NUM];
    int_iq_pkg::br_type_e pick_br [int_iq_pkg::BANK_NUM];
    int_iq_pkg::ras_type_e pick_ras [int_iq_pkg::BANK_NUM];
    logic [int_iq_pkg::BANK_IDX_WIDTH-1:0] order [int_iq_pkg::DISP_WIDTH];

    assign full_o = |bank_full;  // one full bank stalls every slot.

    // slot k lands in the bank ranked k-th by last cycle's occupancy.
    always_comb begin
        bank_wr = '0;
        for (int b = 0; b < int_iq_pkg::BANK_NUM; b++) begin
            bank_status[b] = '0;
            bank_payload[b] = '0;
        end
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            bank_wr[order[k]] = disp_en_i[k] & ~full_o;
            bank_status[order[k]] = disp_status_i[k];
            bank_payload[order[k]] = disp_payload_i[k];
        end
    end

    bank_balance_sort sort_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .count_i (bank_count),
        .order_o (order)
    );

    for (genvar b = 0; b < int_iq_pkg::BANK_NUM; b++) begin : g_bank
        issue_bank bank_i (
            .clk        (clk),
            .rst_i      (rst_i),
            .wr_en_i    (bank_wr[b]),
            .status_i   (bank_status[b]),
            .payload_i  (bank_payload[b]),
            .wakeup_i   (wakeup_i),
            .redirect_i (redirect_i),
            .grant_i    (exu_ready_i[b]),
            .full_o     (bank_full[b]),
            .count_o    (bank_count[b]),
            .pick_en_o  (pick_en[b]),
            .pick_o     (bank_pick[b])
        );

        branch_classify classify_i (
            .branchop_i (bank_pick[b].payload.branchop),
            .rd_i       (bank_pick[b].payload.rd),
            .rs1_i      (bank_pick[b].rs1),
            .br_type_o  (pick_br[b]),
            .ras_type_o (pick_ras[b])
        );

        assign issue_keep[b] = ~redirect_i.valid |
            int_iq_pkg::rob_older(issue_o[b].payload.robIdx, redirect_i.redirectIdx);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_vld_q <= '0;
        end else begin
            issue_vld_q <= pick_en & exu_ready_i;  // only a granted pick leaves its bank.
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < int_iq_pkg::BANK_NUM; b++) begin
            if (pick_en[b]) begin
                issue_o[b].payload <= bank_pick[b].payload;
                issue_o[b].rs1 <= bank_pick[b].rs1;
                issue_o[b].rs2 <= bank_pick[b].rs2;
                issue_o[b].br_type <= pick_br[b];
                issue_o[b].ras_type <= pick_ras[b];
            end
        end
    end

    assign issue_en_o = issue_vld_q & issue_keep;  // a younger op already in flight is dropped.

endmodule

/* test/iq_checks.svh */
`ifndef IQ_CHECKS_SVH
`define IQ_CHECKS_SVH

int err_count = 0;
int checks_run = 0;

task automatic report_fault(input string msg);
    err_count++;
    $display("t=%0t %s", $time, msg);
endtask

task automatic check_issue(input string name, input int_iq_pkg::issue_t got,
                           input int_iq_pkg::issue_t exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

task automatic check_br(input string name, input int_iq_pkg::br_type_e got,
                        input int_iq_pkg::br_type_e exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_ras(input string name, input int_iq_pkg::ras_type_e got,
                         input int_iq_pkg::ras_type_e exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR t=%0t %s got %b exp %b", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    checks_run++;
    if (got != exp) begin
        err_count++;
        $display("ERROR t=%0t %s got %0d exp %0d", $time, name, got, exp);
    end
endtask

`endif

/* test/int_issue_queue_tb.sv */
`timescale 1ns/1ps

module int_issue_queue_tb;

    `include "iq_checks.svh"

    typedef struct packed {
        int_iq_pkg::rob_idx_t rob;
        logic [5:0] rs1;
        logic [5:0] rs2;
        logic [5:0] rd;
        logic [1:0] rdy;  // bit 1 is rs1 valid, bit 0 is rs2 valid.
        logic [2:0] bop;
    } slot_t;

    typedef struct packed {
        logic [3:0] test;
        logic [1:0] en;
        slot_t [int_iq_pkg::DISP_WIDTH-1:0] slot;
        logic wake_en;
        logic [5:0] tag;
        logic redir;
        int_iq_pkg::rob_idx_t ridx;
        logic [1:0] grant;
        logic rnd;  // grant comes from the lfsr when set.
    } row_t;

    localparam int DRAIN_LIMIT = 80;

    logic clk = 1'b0;
    logic rst_i;
    logic [int_iq_pkg::DISP_WIDTH-1:0] disp_en;
    int_iq_pkg::iq_status_t disp_status [int_iq_pkg::DISP_WIDTH];
    int_iq_pkg::iq_payload_t disp_payload [int_iq_pkg::DISP_WIDTH];
    logic full;
    int_iq_pkg::wakeup_t wakeup [int_iq_pkg::WB_SIZE];
    int_iq_pkg::redirect_t redirect;
    logic [int_iq_pkg::BANK_NUM-1:0] exu_ready;
    logic [int_iq_pkg::BANK_NUM-1:0] issue_en;
    int_iq_pkg::issue_t issue [int_iq_pkg::BANK_NUM];

    row_t rows [$];
    logic [31:0] lfsr_state = 32'h2443_2cd4;
    int cyc = 0;
    int pending = 0;
    logic lat_check = 1'b0;
    logic saw_full = 1'b0;
    logic [int_iq_pkg::BANK_NUM-1:0] prev_grant = '0;
    logic exp_valid [64];
    logic exp_wait1 [64];
    logic exp_wait2 [64];
    logic [5:0] exp_tag1 [64];
    logic [5:0] exp_tag2 [64];
    int exp_cyc [64];
    int_iq_pkg::issue_t exp_op [64];

    int_issue_queue dut_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .disp_en_i      (disp_en),
        .disp_status_i  (disp_status),
        .disp_payload_i (disp_payload),
        .full_o         (full),
        .wakeup_i       (wakeup),
        .redirect_i     (redirect),
        .exu_ready_i    (exu_ready),
        .issue_en_o     (issue_en),
        .issue_o        (issue)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic is_link(input logic [5:0] r);
        return (r == 6'd1) || (r == 6'd5);
    endfunction

    function automatic int_iq_pkg::br_type_e expect_br(input logic [2:0] bop,
                                                       input logic [5:0] rd,
                                                       input logic [5:0] rs1);
        if (bop == int_iq_pkg::BRANCH_JAL) return int_iq_pkg::DIRECT;
        if (bop != int_iq_pkg::BRANCH_JALR) return int_iq_pkg::CONDITION;
        if (is_link(rd) || is_link(rs1)) return int_iq_pkg::CALL;
        return int_iq_pkg::INDIRECT;
    endfunction

    function automatic int_iq_pkg::ras_type_e expect_ras(input logic [5:0] rd,
                                                         input logic [5:0] rs1);
        if (is_link(rd) && is_link(rs1)) return int_iq_pkg::POP_PUSH;
        if (is_link(rd)) return int_iq_pkg::PUSH;
        if (is_link(rs1)) return int_iq_pkg::POP;
        return int_iq_pkg::NONE;
    endfunction

    // differing wrap bits flip the plain index comparison.
    function automatic logic is_older(input int_iq_pkg::rob_idx_t a,
                                      input int_iq_pkg::rob_idx_t b);
        return (a.dir != b.dir) != (a.idx < b.idx);
    endfunction

    function automatic slot_t mk_op(input logic [5:0] rob, input logic [5:0] rs1,
                                    input logic [5:0] rs2, input logic [1:0] rdy,
                                    input logic [2:0] bop, input logic [5:0] rd);
        slot_t s;
        s.rob = rob;
        s.rs1 = rs1;
        s.rs2 = rs2;
        s.rd = rd;
        s.rdy = rdy;
        s.bop = bop;
        return s;
    endfunction

    task automatic add_row(input logic [3:0] test, input logic [1:0] en, input slot_t s0,
                           input slot_t s1, input logic wake_en, input logic [5:0] tag,
                           input logic redir, input logic [5:0] ridx, input logic rnd);
        row_t rw;
        rw = '0;
        rw.test = test;
        rw.en = en;
        rw.slot[0] = s0;
        rw.slot[1] = s1;
        rw.wake_en = wake_en;
        rw.tag = tag;
        rw.redir = redir;
        rw.ridx = ridx;
        rw.grant = 2'b11;
        rw.rnd = rnd;
        rows.push_back(rw);
    endtask

    task automatic apply_row(input row_t rw);
        logic [31:0] v;
        int_iq_pkg::iq_status_t st;
        int_iq_pkg::iq_payload_t pl;
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            st.rs1 = rw.slot[k].rs1;
            st.rs2 = rw.slot[k].rs2;
            st.rs1v = rw.slot[k].rdy[1];
            st.rs2v = rw.slot[k].rdy[0];
            st.robIdx = rw.slot[k].rob;
            take_bits(20, v);
            pl.imm = v[19:0];
            take_bits(4, v);
            pl.aluop = v[3:0];
            pl.rd = rw.slot[k].rd;
            pl.branchop = rw.slot[k].bop;
            pl.robIdx = rw.slot[k].rob;
            disp_en[k] <= rw.en[k];
            disp_status[k] <= st;
            disp_payload[k] <= pl;
        end
        wakeup[0] <= '0;
        wakeup[1] <= '0;
        wakeup[rw.tag[0]] <= {rw.wake_en, 1'b1, rw.tag};  // odd tags use the second port.
        redirect <= {rw.redir, rw.ridx};
        if (rw.rnd) begin
            take_bits(2, v);
            exu_ready <= v[1:0];
        end else begin
            exu_ready <= rw.grant;
        end
    endtask

    // the scoreboard samples on the falling edge where inputs and outputs have settled.
    always @(negedge clk) begin
        logic [5:0] r;
        int_iq_pkg::issue_t e;
        if (!rst_i) begin
            for (int b = 0; b < int_iq_pkg::BANK_NUM; b++) begin
                if (issue_en[b]) begin
                    r = issue[b].payload.robIdx;
                    if (!prev_grant[b]) begin
                        report_fault($sformatf("bank %0d issued without grant", b));
                    end
                    if (!exp_valid[r]) begin
                        report_fault($sformatf("unexpected issue of rob %h", r));
                    end else begin
                        if (exp_wait1[r] || exp_wait2[r]) begin
                            report_fault($sformatf("rob %h issued before its wakeup", r));
                        end
                        check_issue("issue_o", issue[b], exp_op[r]);
                        check_br("issue_o.br_type", issue[b].br_type, exp_op[r].br_type);
                        check_ras("issue_o.ras_type", issue[b].ras_type, exp_op[r].ras_type);
                        if (lat_check) check_count("issue latency", cyc - exp_cyc[r], 2);
                        exp_valid[r] = 1'b0;
                        pending--;
                    end
                end
            end
            if (redirect.valid) begin
                for (int i = 0; i < 64; i++) begin
                    if (exp_valid[i] && !is_older(i[5:0], redirect.redirectIdx)) begin
                        exp_valid[i] = 1'b0;
                        pending--;
                    end
                end
            end
            for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
                r = disp_status[k].robIdx;
                if (disp_en[k] && !full &&
                    (!redirect.valid || is_older(r, redirect.redirectIdx))) begin
                    e.payload = disp_payload[k];
                    e.rs1 = disp_status[k].rs1;
                    e.rs2 = disp_status[k].rs2;
                    e.br_type = expect_br(disp_payload[k].branchop, disp_payload[k].rd, e.rs1);
                    e.ras_type = expect_ras(disp_payload[k].rd, e.rs1);
                    exp_op[r] = e;
                    exp_valid[r] = 1'b1;
                    exp_cyc[r] = cyc;
                    exp_wait1[r] = !disp_status[k].rs1v;
                    exp_wait2[r] = !disp_status[k].rs2v;
                    exp_tag1[r] = e.rs1;
                    exp_tag2[r] = e.rs2;
                    pending++;
                end
            end
            for (int p = 0; p < int_iq_pkg::WB_SIZE; p++) begin
                if (wakeup[p].en && wakeup[p].we) begin
                    for (int i = 0; i < 64; i++) begin
                        if (exp_tag1[i] == wakeup[p].rd) exp_wait1[i] = 1'b0;
                        if (exp_tag2[i] == wakeup[p].rd) exp_wait2[i] = 1'b0;
                    end
                end
            end
            if (full) saw_full = 1'b1;
            prev_grant = exu_ready;
        end
    end

    initial begin
        int n;
        int err0;
        row_t idle;
        slot_t nop;
        logic [5:0] rb;
        rst_i = 1'b1;
        disp_en = '0;
        redirect = '0;
        exu_ready = '0;
        for (int k = 0; k < int_iq_pkg::DISP_WIDTH; k++) begin
            disp_status[k] = '0;
            disp_payload[k] = '0;
        end
        for (int p = 0; p < int_iq_pkg::WB_SIZE; p++) wakeup[p] = '0;
        for (int i = 0; i < 64; i++) begin
            exp_valid[i] = 1'b0;
            exp_wait1[i] = 1'b0;
            exp_wait2[i] = 1'b0;
            exp_tag1[i] = '0;
            exp_tag2[i] = '0;
        end
        idle = '0;
        idle.grant = 2'b11;
        nop = '0;

        // ready ops of every branch class go in one per cycle.
        add_row(4'd2, 2'b01, mk_op(6'h01, 6'd7, 6'd8, 2'b11, 3'b100, 6'd1), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd2, 2'b01, mk_op(6'h02, 6'd6, 6'd8, 2'b11, 3'b101, 6'd1), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd2, 2'b01, mk_op(6'h03, 6'd6, 6'd8, 2'b11, 3'b101, 6'd0), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd2, 2'b01, mk_op(6'h04, 6'd5, 6'd8, 2'b11, 3'b000, 6'd0), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd2, 2'b01, mk_op(6'h05, 6'd1, 6'd8, 2'b11, 3'b101, 6'd5), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        // two waiting ops see a wakeup on an unrelated tag first.
        add_row(4'd3, 2'b11, mk_op(6'h06, 6'd10, 6'd9, 2'b01, 3'b000, 6'd2),
                mk_op(6'h07, 6'd9, 6'd11, 2'b10, 3'b000, 6'd3), 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        for (int j = 0; j < 3; j++) add_row(4'd3, 2'b00, nop, nop, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd3, 2'b00, nop, nop, 1'b1, 6'd12, 1'b0, 6'd0, 1'b0);
        add_row(4'd3, 2'b00, nop, nop, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd3, 2'b00, nop, nop, 1'b1, 6'd10, 1'b0, 6'd0, 1'b0);
        add_row(4'd3, 2'b00, nop, nop, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd3, 2'b00, nop, nop, 1'b1, 6'd11, 1'b0, 6'd0, 1'b0);
        // more waiting ops than the banks can hold.
        for (int j = 0; j < 6; j++) begin
            rb = 6'h08 + 6'(2 * j);
            add_row(4'd4, 2'b11, mk_op(rb, 6'd20, 6'd9, 2'b01, 3'b000, 6'd2),
                    mk_op(rb + 6'd1, 6'd20, 6'd9, 2'b01, 3'b000, 6'd3),
                    1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        end
        add_row(4'd4, 2'b00, nop, nop, 1'b1, 6'd20, 1'b0, 6'd0, 1'b0);
        // one op sits past the wrap and the ready one is in flight at the redirect.
        add_row(4'd5, 2'b11, mk_op(6'h1C, 6'd30, 6'd9, 2'b01, 3'b000, 6'd2),
                mk_op(6'h1D, 6'd30, 6'd9, 2'b01, 3'b000, 6'd2), 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd5, 2'b11, mk_op(6'h1E, 6'd30, 6'd9, 2'b01, 3'b000, 6'd2),
                mk_op(6'h21, 6'd30, 6'd9, 2'b01, 3'b000, 6'd2), 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd5, 2'b01, mk_op(6'h1F, 6'd7, 6'd9, 2'b11, 3'b000, 6'd2), nop,
                1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd5, 2'b00, nop, nop, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0);
        add_row(4'd5, 2'b00, nop, nop, 1'b0, 6'd0, 1'b1, 6'h1E, 1'b0);
        add_row(4'd5, 2'b00, nop, nop, 1'b1, 6'd30, 1'b0, 6'd0, 1'b0);
        // ready ops under a random grant.
        add_row(4'd6, 2'b11, mk_op(6'h28, 6'd7, 6'd9, 2'b11, 3'b100, 6'd1),
                mk_op(6'h29, 6'd7, 6'd9, 2'b11, 3'b000, 6'd2), 1'b0, 6'd0, 1'b0, 6'd0, 1'b1);
        add_row(4'd6, 2'b11, mk_op(6'h2A, 6'd1, 6'd9, 2'b11, 3'b101, 6'd0),
                mk_op(6'h2B, 6'd7, 6'd9, 2'b11, 3'b101, 6'd3), 1'b0, 6'd0, 1'b0, 6'd0, 1'b1);
        for (int j = 0; j < 8; j++) add_row(4'd6, 2'b00, nop, nop, 1'b0, 6'd0, 1'b0, 6'd0, 1'b1);

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        exu_ready <= 2'b11;
        @(negedge clk);
        err0 = err_count;
        check_flag("issue_en_o", |issue_en, 1'b0);
        check_flag("full_o", full, 1'b0);
        $display("test 1 reset state: %s", (err_count == err0) ? "ok" : "failed");

        for (int t = 2; t <= 6; t++) begin
            err0 = err_count;
            lat_check = (t == 2);
            saw_full = 1'b0;
            foreach (rows[i]) begin
                if (rows[i].test == 4'(t)) begin
                    @(posedge clk);
                    apply_row(rows[i]);
                end
            end
            @(posedge clk);
            apply_row(idle);
            n = 0;
            while (pending != 0 && n < DRAIN_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (pending != 0) begin
                $display("timeout in test %0d: %0d ops never issued", t, pending);
                $display("TEST FAILED");
                $finish;
            end
            repeat (4) @(posedge clk);
            @(negedge clk);
            if (t == 4) check_flag("full_o seen", saw_full, 1'b1);
            check_flag("full_o", full, 1'b0);
            $display("test %0d: %s", t, (err_count == err0) ? "ok" : "failed");
        end

        $display("checks %0d, errors %0d", checks_run, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* int_issue_queue.f */
+incdir+test
logic/int_iq_pkg.sv
logic/oldest_ready_picker.sv
logic/issue_bank.sv
logic/bank_balance_sort.sv
logic/branch_classify.sv
logic/int_issue_queue.sv
test/int_issue_queue_tb.sv

/* Makefile */
TOP := int_issue_queue_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): int_issue_queue.f logic/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -f int_issue_queue.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -f int_issue_queue.f --top-module int_issue_queue

clean:
	rm -rf obj_dir sim.log
